// File: src/decode_issue_pkg.sv
package decode_issue_pkg;

    // datapath and rob sizing
    localparam int XLEN        = 32;
    localparam int ROB_ENTRIES = 16;
    localparam int TAG_W       = 4;
    localparam int REG_W       = 5;

    typedef logic [XLEN-1:0]  word_t;
    // tag zero marks an operand that needs no wakeup
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [REG_W-1:0] reg_idx_t;

    // rv32i major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // low five codes line up with funct3
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        // sub sits outside the funct3 range
        alu_sub = 4'b1000
    } alu_op_e;

    // branch conditions, straight from funct3
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_op_e;

    // where an instruction goes
    typedef enum logic [1:0] {
        tgt_none = 2'd0,
        tgt_alu  = 2'd1,
        tgt_cmp  = 2'd2,
        tgt_lsb  = 2'd3
    } target_e;

    // one result word per rob entry, entry n at [n]
    typedef logic [ROB_ENTRIES-1:0][XLEN-1:0] rob_values_t;

endpackage

// File: src/decode_if.sv
`timescale 1ns/1ps

// decoded fields, decode_fields to issue_ctrl and dispatch_regs
interface decode_if;
    decode_issue_pkg::opcode_e  opcode;
    logic [2:0]                 funct3;
    logic                       funct7_5;
    decode_issue_pkg::reg_idx_t rs1;
    decode_issue_pkg::reg_idx_t rs2;
    decode_issue_pkg::reg_idx_t rd;
    decode_issue_pkg::word_t    pc;
    // already picked by opcode
    decode_issue_pkg::word_t    imm;
    logic                       writes_rd;

    modport src (output opcode, funct3, funct7_5, rs1, rs2, rd, pc, imm, writes_rd);
    modport snk (input opcode, funct3, funct7_5, rs1, rs2, rd, pc, imm, writes_rd);
endinterface

// issue decision, issue_ctrl to dispatch_regs
interface issue_if;
    logic                              fire;
    decode_issue_pkg::target_e         target;
    decode_issue_pkg::alu_op_e         alu_op;
    decode_issue_pkg::word_t           op_a;
    decode_issue_pkg::tag_t            op_a_tag;
    decode_issue_pkg::word_t           op_b;
    decode_issue_pkg::tag_t            op_b_tag;
    decode_issue_pkg::tag_t            rob_tag;

    modport src (output fire, target, alu_op, op_a, op_a_tag, op_b, op_b_tag, rob_tag);
    modport snk (input fire, target, alu_op, op_a, op_a_tag, op_b, op_b_tag, rob_tag);
endinterface

// File: src/decode_fields.sv
`timescale 1ns/1ps

module decode_fields (
    input  decode_issue_pkg::word_t instr_i,
    input  decode_issue_pkg::word_t pc_i,
    decode_if.src                   dec
);

    decode_issue_pkg::word_t   i_imm;
    decode_issue_pkg::word_t   s_imm;
    decode_issue_pkg::word_t   b_imm;
    decode_issue_pkg::word_t   u_imm;
    decode_issue_pkg::opcode_e opcode;

    assign opcode = decode_issue_pkg::opcode_e'(instr_i[6:0]);

    // plain field slices
    assign dec.opcode   = opcode;
    assign dec.funct3   = instr_i[14:12];
    assign dec.funct7_5 = instr_i[30];
    assign dec.rs1      = instr_i[19:15];
    assign dec.rs2      = instr_i[24:20];
    assign dec.rd       = instr_i[11:7];
    assign dec.pc       = pc_i;

    // immediates, sign bit is always instr[31]
    assign i_imm = {{21{instr_i[31]}}, instr_i[30:20]};
    assign s_imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign u_imm = {instr_i[31:12], 12'h000};

    always_comb begin
        case (opcode)
            decode_issue_pkg::op_auipc: dec.imm = u_imm;
            decode_issue_pkg::op_br:    dec.imm = b_imm;
            decode_issue_pkg::op_store: dec.imm = s_imm;
            // loads and op-imm share the I form
            default:                    dec.imm = i_imm;
        endcase
    end

    // only these four groups produce a register result
    always_comb begin
        case (opcode)
            decode_issue_pkg::op_auipc,
            decode_issue_pkg::op_load,
            decode_issue_pkg::op_imm,
            decode_issue_pkg::op_reg:   dec.writes_rd = 1'b1;
            default:                    dec.writes_rd = 1'b0;
        endcase
    end

endmodule

// File: src/operand_resolve.sv
`timescale 1ns/1ps

module operand_resolve (
    input  decode_issue_pkg::word_t                     reg_vj_i,
    input  decode_issue_pkg::word_t                     reg_vk_i,
    input  decode_issue_pkg::tag_t                      reg_qj_i,
    input  decode_issue_pkg::tag_t                      reg_qk_i,
    input  logic [decode_issue_pkg::ROB_ENTRIES-1:0]    rob_ready_i,
    input  decode_issue_pkg::rob_values_t               rob_value_i,
    output decode_issue_pkg::word_t                     vj_o,
    output decode_issue_pkg::word_t                     vk_o,
    output decode_issue_pkg::tag_t                      qj_o,
    output decode_issue_pkg::tag_t                      qk_o
);

    // true when the producer already finished in the rob
    function automatic logic hit(input decode_issue_pkg::tag_t tag);
        hit = (tag != '0) && rob_ready_i[tag];
    endfunction

    // rs1
    always_comb begin
        if (hit(reg_qj_i)) begin
            vj_o = rob_value_i[reg_qj_i];
            qj_o = '0;
        end else begin
            vj_o = reg_vj_i;
            qj_o = reg_qj_i;
        end
    end

    // rs2, same rule
    always_comb begin
        if (hit(reg_qk_i)) begin
            vk_o = rob_value_i[reg_qk_i];
            qk_o = '0;
        end else begin
            vk_o = reg_vk_i;
            qk_o = reg_qk_i;
        end
    end

endmodule

// File: src/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
    decode_if.snk                   dec,
    input  logic                    instr_valid_i,
    input  decode_issue_pkg::word_t vj_i,
    input  decode_issue_pkg::word_t vk_i,
    input  decode_issue_pkg::tag_t  qj_i,
    input  decode_issue_pkg::tag_t  qk_i,
    input  logic                    alu_full_i,
    input  logic                    cmp_full_i,
    input  logic                    lsb_full_i,
    input  decode_issue_pkg::tag_t  rob_free_tag_i,
    output logic                    iqueue_read_o,
    output logic                    load_tag_o,
    output decode_issue_pkg::tag_t  rename_tag_o,
    issue_if.src                    iss
);

    decode_issue_pkg::target_e target;
    logic                      need_dispatch;
    logic                      target_full;

    // target and alu op; tgt_none marks an unsupported code
    always_comb begin
        target     = decode_issue_pkg::tgt_none;
        iss.alu_op = decode_issue_pkg::alu_op_e'({1'b0, dec.funct3});
        case (dec.opcode)
            decode_issue_pkg::op_auipc: begin
                target     = decode_issue_pkg::tgt_alu;
                iss.alu_op = decode_issue_pkg::alu_add;
            end
            // funct3 010 and 011 are not branches
            decode_issue_pkg::op_br:
                if (dec.funct3[2:1] != 2'b01) target = decode_issue_pkg::tgt_cmp;
            // lb lh lw lbu lhu
            decode_issue_pkg::op_load:
                if (dec.funct3 != 3'b011 && dec.funct3 < 3'b110) target = decode_issue_pkg::tgt_lsb;
            decode_issue_pkg::op_store:
                if (dec.funct3 < 3'b011) target = decode_issue_pkg::tgt_lsb;
            // slt, sltu and right shifts stay unsupported
            decode_issue_pkg::op_imm,
            decode_issue_pkg::op_reg: begin
                if (dec.funct3 inside {3'b000, 3'b001, 3'b100, 3'b110, 3'b111})
                    target = decode_issue_pkg::tgt_alu;
                if (dec.opcode == decode_issue_pkg::op_reg && dec.funct3 == 3'b000 && dec.funct7_5)
                    iss.alu_op = decode_issue_pkg::alu_sub;
            end
            default: ;
        endcase
    end

    // operand a is pc for auipc, rs1 otherwise
    assign iss.op_a     = (dec.opcode == decode_issue_pkg::op_auipc) ? dec.pc : vj_i;
    assign iss.op_a_tag = (dec.opcode == decode_issue_pkg::op_auipc) ? '0 : qj_i;
    // immediate forms put the immediate in operand b
    always_comb begin
        case (dec.opcode)
            decode_issue_pkg::op_br,
            decode_issue_pkg::op_reg,
            decode_issue_pkg::op_store: begin
                iss.op_b     = vk_i;
                iss.op_b_tag = qk_i;
            end
            default: begin
                iss.op_b     = dec.imm;
                iss.op_b_tag = '0;
            end
        endcase
    end

    // x0 writes and unknown codes are dropped
    assign need_dispatch = (target != decode_issue_pkg::tgt_none) &&
                           !(dec.writes_rd && dec.rd == '0);
    assign target_full   = (target == decode_issue_pkg::tgt_alu && alu_full_i) ||
                           (target == decode_issue_pkg::tgt_cmp && cmp_full_i) ||
                           (target == decode_issue_pkg::tgt_lsb && lsb_full_i);

    assign iss.fire    = instr_valid_i && need_dispatch && !target_full && rob_free_tag_i != '0;
    assign iss.target  = target;
    assign iss.rob_tag = rob_free_tag_i;

    // pop on issue or on drop, hold on stall
    assign iqueue_read_o = instr_valid_i && (iss.fire || !need_dispatch);
    // rename only for issuing rd writers
    assign load_tag_o    = iss.fire && dec.writes_rd;
    assign rename_tag_o  = load_tag_o ? rob_free_tag_i : '0;

endmodule

// File: src/dispatch_regs.sv
`timescale 1ns/1ps

module dispatch_regs (
    input  logic                         clk,
    input  logic                         rst,
    decode_if.snk                        dec,
    issue_if.snk                         iss,
    output logic                         alu_valid_o,
    output logic                         cmp_valid_o,
    output logic                         lsb_valid_o,
    output decode_issue_pkg::alu_op_e    alu_op_o,
    output decode_issue_pkg::branch_op_e cmp_op_o,
    output logic                         lsb_store_o,
    output logic [2:0]                   lsb_funct3_o,
    output decode_issue_pkg::word_t      op_a_o,
    output decode_issue_pkg::word_t      op_b_o,
    output decode_issue_pkg::word_t      imm_o,
    output decode_issue_pkg::tag_t       op_a_tag_o,
    output decode_issue_pkg::tag_t       op_b_tag_o,
    output decode_issue_pkg::tag_t       rob_tag_o,
    output logic                         rob_write_o,
    output decode_issue_pkg::word_t      rob_pc_o,
    output decode_issue_pkg::opcode_e    rob_opcode_o,
    output decode_issue_pkg::reg_idx_t   rob_rd_o
);

    // valid pulses, one cycle per fire
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid_o <= 1'b0;
            cmp_valid_o <= 1'b0;
            lsb_valid_o <= 1'b0;
            rob_write_o <= 1'b0;
        end else begin
            alu_valid_o <= iss.fire && iss.target == decode_issue_pkg::tgt_alu;
            cmp_valid_o <= iss.fire && iss.target == decode_issue_pkg::tgt_cmp;
            lsb_valid_o <= iss.fire && iss.target == decode_issue_pkg::tgt_lsb;
            // every dispatch also claims a rob entry
            rob_write_o <= iss.fire;
        end
    end

    // shared payload, only meaningful under a valid
    always_ff @(posedge clk) begin
        if (iss.fire) begin
            alu_op_o     <= iss.alu_op;
            cmp_op_o     <= decode_issue_pkg::branch_op_e'(dec.funct3);
            lsb_store_o  <= (dec.opcode == decode_issue_pkg::op_store);
            lsb_funct3_o <= dec.funct3;
            op_a_o       <= iss.op_a;
            op_a_tag_o   <= iss.op_a_tag;
            op_b_o       <= iss.op_b;
            op_b_tag_o   <= iss.op_b_tag;
            imm_o        <= dec.imm;
            rob_tag_o    <= iss.rob_tag;
            rob_pc_o     <= dec.pc;
            rob_opcode_o <= dec.opcode;
            // branch and store rd bits are immediate bits
            rob_rd_o     <= dec.writes_rd ? dec.rd : '0;
        end
    end

    // one station per cycle
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({alu_valid_o, cmp_valid_o, lsb_valid_o}))
        else $error("more than one dispatch valid in a cycle");

    // rob entry and station entry go together
    assert property (@(posedge clk) disable iff (rst)
        rob_write_o == (alu_valid_o | cmp_valid_o | lsb_valid_o))
        else $error("rob write out of step with dispatch");

    // tag zero is reserved for no producer
    assert property (@(posedge clk) disable iff (rst)
        rob_write_o |-> rob_tag_o != '0)
        else $error("rob write with tag zero");

endmodule

// File: src/decode_issue_top.sv
`timescale 1ns/1ps

module decode_issue_top (
    input  logic                                    clk,
    input  logic                                    rst,
    // instruction queue
    input  logic                                    instr_valid_i,
    input  decode_issue_pkg::word_t                 instr_i,
    input  decode_issue_pkg::word_t                 pc_i,
    output logic                                    iqueue_read_o,
    // register file read and rename
    output decode_issue_pkg::reg_idx_t              rs1_o,
    output decode_issue_pkg::reg_idx_t              rs2_o,
    input  decode_issue_pkg::word_t                 reg_vj_i,
    input  decode_issue_pkg::word_t                 reg_vk_i,
    input  decode_issue_pkg::tag_t                  reg_qj_i,
    input  decode_issue_pkg::tag_t                  reg_qk_i,
    output decode_issue_pkg::reg_idx_t              rename_rd_o,
    output decode_issue_pkg::tag_t                  rename_tag_o,
    output logic                                    load_tag_o,
    // reorder buffer
    input  decode_issue_pkg::tag_t                  rob_free_tag_i,
    input  logic [decode_issue_pkg::ROB_ENTRIES-1:0] rob_ready_i,
    input  decode_issue_pkg::rob_values_t           rob_value_i,
    // station back-pressure
    input  logic                                    alu_full_i,
    input  logic                                    cmp_full_i,
    input  logic                                    lsb_full_i,
    // dispatch
    output logic                                    alu_valid_o,
    output logic                                    cmp_valid_o,
    output logic                                    lsb_valid_o,
    output decode_issue_pkg::alu_op_e               alu_op_o,
    output decode_issue_pkg::branch_op_e            cmp_op_o,
    output logic                                    lsb_store_o,
    output logic [2:0]                              lsb_funct3_o,
    output decode_issue_pkg::word_t                 op_a_o,
    output decode_issue_pkg::word_t                 op_b_o,
    output decode_issue_pkg::word_t                 imm_o,
    output decode_issue_pkg::tag_t                  op_a_tag_o,
    output decode_issue_pkg::tag_t                  op_b_tag_o,
    output decode_issue_pkg::tag_t                  rob_tag_o,
    output logic                                    rob_write_o,
    output decode_issue_pkg::word_t                 rob_pc_o,
    output decode_issue_pkg::opcode_e               rob_opcode_o,
    output decode_issue_pkg::reg_idx_t              rob_rd_o
);

    decode_if dec ();
    issue_if  iss ();

    decode_issue_pkg::word_t vj, vk;
    decode_issue_pkg::tag_t  qj, qk;

    // register file indices straight off the instruction
    assign rs1_o       = dec.rs1;
    assign rs2_o       = dec.rs2;
    assign rename_rd_o = dec.rd;

    decode_fields u_fields (.instr_i(instr_i), .pc_i(pc_i), .dec(dec.src));

    operand_resolve u_resolve (
        .reg_vj_i(reg_vj_i), .reg_vk_i(reg_vk_i), .reg_qj_i(reg_qj_i), .reg_qk_i(reg_qk_i),
        .rob_ready_i(rob_ready_i), .rob_value_i(rob_value_i),
        .vj_o(vj), .vk_o(vk), .qj_o(qj), .qk_o(qk)
    );

    issue_ctrl u_issue (
        .dec(dec.snk), .instr_valid_i(instr_valid_i),
        .vj_i(vj), .vk_i(vk), .qj_i(qj), .qk_i(qk),
        .alu_full_i(alu_full_i), .cmp_full_i(cmp_full_i), .lsb_full_i(lsb_full_i),
        .rob_free_tag_i(rob_free_tag_i), .iqueue_read_o(iqueue_read_o),
        .load_tag_o(load_tag_o), .rename_tag_o(rename_tag_o), .iss(iss.src)
    );

    dispatch_regs u_dispatch (
        .clk(clk), .rst(rst), .dec(dec.snk), .iss(iss.snk),
        .alu_valid_o(alu_valid_o), .cmp_valid_o(cmp_valid_o), .lsb_valid_o(lsb_valid_o),
        .alu_op_o(alu_op_o), .cmp_op_o(cmp_op_o),
        .lsb_store_o(lsb_store_o), .lsb_funct3_o(lsb_funct3_o),
        .op_a_o(op_a_o), .op_b_o(op_b_o), .imm_o(imm_o),
        .op_a_tag_o(op_a_tag_o), .op_b_tag_o(op_b_tag_o), .rob_tag_o(rob_tag_o),
        .rob_write_o(rob_write_o), .rob_pc_o(rob_pc_o),
        .rob_opcode_o(rob_opcode_o), .rob_rd_o(rob_rd_o)
    );

endmodule

// File: verification/decode_issue_checker.sv
`timescale 1ns/1ps

module decode_issue_checker (
    input  logic        clk,
    input  logic        rst,
    // stimulus and golden expectations of the cycle
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    input  logic [3:0]  rob_free_tag_i,
    input  int          test_id_i,
    input  logic [31:0] exp_ctl_i,
    input  logic [31:0] exp_op_a_i,
    input  logic [31:0] exp_op_b_i,
    input  logic [31:0] exp_imm_i,
    input  logic [4:0]  exp_rd_i,
    // same-cycle dut outputs
    input  logic        iqueue_read_i,
    input  logic        load_tag_i,
    input  logic [3:0]  rename_tag_i,
    input  logic [4:0]  rs1_i, rs2_i, rename_rd_i,
    // registered dispatch outputs
    input  logic        alu_valid_i, cmp_valid_i, lsb_valid_i, rob_write_i,
    input  logic [3:0]  alu_op_i,
    input  logic [2:0]  cmp_op_i,
    input  logic        lsb_store_i,
    input  logic [2:0]  lsb_funct3_i,
    input  logic [31:0] op_a_i, op_b_i, imm_i, rob_pc_i,
    input  logic [3:0]  op_a_tag_i, op_b_tag_i, rob_tag_i,
    input  logic [4:0]  rob_rd_i,
    input  logic [6:0]  rob_opcode_i,
    output int          pass_count_o,
    output int          fail_count_o,
    output int          done_count_o
);

    // instruction seen last cycle, dispatch still due
    logic        pend;
    int          pend_id;
    int          pend_errs;
    logic [31:0] pend_ctl, pend_op_a, pend_op_b, pend_imm, pend_pc;
    logic [31:0] pend_instr;
    logic [3:0]  pend_tag;
    logic [4:0]  pend_rd;
    // mismatches of the test under check
    int          errs;
    logic [3:0]  exp_tgt;

    task automatic compare_field(input int id, input string what,
                                 input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: test %0d %s is %h, expected %h", $time, id, what, got, exp);
            errs++;
        end
    endtask

    task automatic finish_test(input int id, input int n_err);
        if (n_err == 0) begin
            pass_count_o++;
            $display("test %0d ok", id);
        end else begin
            fail_count_o++;
            $display("test %0d bad, %0d mismatches", id, n_err);
        end
        done_count_o++;
    endtask

    // sampled mid-cycle, away from the posedge updates
    always @(negedge clk) begin
        if (rst) begin
            pend         = 1'b0;
            pend_id      = -1;
            pass_count_o = 0;
            fail_count_o = 0;
            done_count_o = 0;
        end else begin
            // dispatch of last cycle's instruction, or nothing at all
            errs    = pend ? pend_errs : 0;
            exp_tgt = pend ? pend_ctl[19:16] : 4'd0;
            compare_field(pend_id, "alu_valid", alu_valid_i, exp_tgt == 4'd1);
            compare_field(pend_id, "cmp_valid", cmp_valid_i, exp_tgt == 4'd2);
            compare_field(pend_id, "lsb_valid", lsb_valid_i, exp_tgt == 4'd3);
            compare_field(pend_id, "rob_write", rob_write_i, exp_tgt != 4'd0);
            if (exp_tgt != 4'd0) begin
                compare_field(pend_id, "op_a", op_a_i, pend_op_a);
                compare_field(pend_id, "op_a_tag", op_a_tag_i, pend_ctl[7:4]);
                compare_field(pend_id, "op_b", op_b_i, pend_op_b);
                compare_field(pend_id, "op_b_tag", op_b_tag_i, pend_ctl[3:0]);
                compare_field(pend_id, "imm", imm_i, pend_imm);
                // rob entry takes the free tag and the pc
                compare_field(pend_id, "rob_tag", rob_tag_i, pend_tag);
                compare_field(pend_id, "rob_pc", rob_pc_i, pend_pc);
                compare_field(pend_id, "rob_rd", rob_rd_i, pend_rd);
                // major opcode sits in the low seven instruction bits
                compare_field(pend_id, "rob_opcode", rob_opcode_i, pend_instr[6:0]);
                case (exp_tgt)
                    4'd1: compare_field(pend_id, "alu_op", alu_op_i, pend_ctl[15:12]);
                    4'd2: compare_field(pend_id, "cmp_op", cmp_op_i, pend_ctl[15:12]);
                    default: begin
                        compare_field(pend_id, "lsb_funct3", lsb_funct3_i, pend_ctl[15:12]);
                        compare_field(pend_id, "lsb_store", lsb_store_i, pend_ctl[11:8]);
                    end
                endcase
            end
            if (pend) begin
                finish_test(pend_id, errs);
            end else if (errs != 0) begin
                $display("dispatch seen at %0t without an instruction the cycle before", $time);
                fail_count_o++;
            end
            pend    = 1'b0;
            pend_id = -1;
            // pop and rename answer in the same cycle
            if (instr_valid_i) begin
                errs = 0;
                compare_field(test_id_i, "iqueue_read", iqueue_read_i, exp_ctl_i[28]);
                compare_field(test_id_i, "load_tag", load_tag_i, exp_ctl_i[24]);
                compare_field(test_id_i, "rename_tag", rename_tag_i, exp_ctl_i[23:20]);
                // register file and rename indices, rv32i field positions
                compare_field(test_id_i, "rs1", rs1_i, instr_i[19:15]);
                compare_field(test_id_i, "rs2", rs2_i, instr_i[24:20]);
                compare_field(test_id_i, "rename_rd", rename_rd_i, instr_i[11:7]);
                pend       = 1'b1;
                pend_id    = test_id_i;
                pend_errs  = errs;
                pend_ctl   = exp_ctl_i;
                pend_op_a  = exp_op_a_i;
                pend_op_b  = exp_op_b_i;
                pend_imm   = exp_imm_i;
                pend_pc    = pc_i;
                pend_instr = instr_i;
                pend_tag   = rob_free_tag_i;
                pend_rd    = exp_rd_i;
            end
        end
    end

endmodule

// File: verification/decode_issue_tb.sv
`timescale 1ns/1ps

module decode_issue_tb;

    localparam int NUM_TESTS    = 21;
    // hex words per golden line
    localparam int FIELDS       = 10;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;

    logic                                     clk;
    logic                                     rst;
    logic                                     instr_valid_i;
    decode_issue_pkg::word_t                  instr_i, pc_i, reg_vj_i, reg_vk_i;
    decode_issue_pkg::tag_t                   reg_qj_i, reg_qk_i, rob_free_tag_i;
    logic [decode_issue_pkg::ROB_ENTRIES-1:0] rob_ready_i;
    decode_issue_pkg::rob_values_t            rob_value_i;
    logic                                     alu_full_i, cmp_full_i, lsb_full_i;
    // dut outputs
    logic        iqueue_read_o, load_tag_o, rob_write_o, lsb_store_o;
    logic        alu_valid_o, cmp_valid_o, lsb_valid_o;
    logic [4:0]  rs1_o, rs2_o, rename_rd_o, rob_rd_o;
    logic [3:0]  rename_tag_o, op_a_tag_o, op_b_tag_o, rob_tag_o, alu_op_o;
    logic [2:0]  cmp_op_o, lsb_funct3_o;
    logic [6:0]  rob_opcode_o;
    logic [31:0] op_a_o, op_b_o, imm_o, rob_pc_o;
    // golden image and what the checker expects this cycle
    logic [31:0] golden [NUM_TESTS*FIELDS];
    logic [31:0] exp_ctl, exp_op_a, exp_op_b, exp_imm;
    logic [4:0]  exp_rd;
    int          test_id;
    int          pass_count, fail_count, done_count;

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    decode_issue_top decode_issue_top_i (
        .clk(clk), .rst(rst), .instr_valid_i(instr_valid_i), .instr_i(instr_i), .pc_i(pc_i),
        .iqueue_read_o(iqueue_read_o), .rs1_o(rs1_o), .rs2_o(rs2_o),
        .reg_vj_i(reg_vj_i), .reg_vk_i(reg_vk_i), .reg_qj_i(reg_qj_i), .reg_qk_i(reg_qk_i),
        .rename_rd_o(rename_rd_o), .rename_tag_o(rename_tag_o), .load_tag_o(load_tag_o),
        .rob_free_tag_i(rob_free_tag_i), .rob_ready_i(rob_ready_i), .rob_value_i(rob_value_i),
        .alu_full_i(alu_full_i), .cmp_full_i(cmp_full_i), .lsb_full_i(lsb_full_i),
        .alu_valid_o(alu_valid_o), .cmp_valid_o(cmp_valid_o), .lsb_valid_o(lsb_valid_o),
        .alu_op_o(alu_op_o), .cmp_op_o(cmp_op_o), .lsb_store_o(lsb_store_o),
        .lsb_funct3_o(lsb_funct3_o), .op_a_o(op_a_o), .op_b_o(op_b_o), .imm_o(imm_o),
        .op_a_tag_o(op_a_tag_o), .op_b_tag_o(op_b_tag_o), .rob_tag_o(rob_tag_o),
        .rob_write_o(rob_write_o), .rob_pc_o(rob_pc_o), .rob_opcode_o(rob_opcode_o),
        .rob_rd_o(rob_rd_o)
    );

    decode_issue_checker result_check (
        .clk(clk), .rst(rst), .instr_valid_i(instr_valid_i), .instr_i(instr_i), .pc_i(pc_i),
        .rob_free_tag_i(rob_free_tag_i), .test_id_i(test_id), .exp_ctl_i(exp_ctl),
        .exp_op_a_i(exp_op_a), .exp_op_b_i(exp_op_b), .exp_imm_i(exp_imm), .exp_rd_i(exp_rd),
        .iqueue_read_i(iqueue_read_o), .load_tag_i(load_tag_o), .rename_tag_i(rename_tag_o),
        .rs1_i(rs1_o), .rs2_i(rs2_o), .rename_rd_i(rename_rd_o),
        .alu_valid_i(alu_valid_o), .cmp_valid_i(cmp_valid_o), .lsb_valid_i(lsb_valid_o),
        .rob_write_i(rob_write_o), .alu_op_i(alu_op_o), .cmp_op_i(cmp_op_o),
        .lsb_store_i(lsb_store_o), .lsb_funct3_i(lsb_funct3_o), .op_a_i(op_a_o),
        .op_b_i(op_b_o), .imm_i(imm_o), .rob_pc_i(rob_pc_o), .op_a_tag_i(op_a_tag_o),
        .op_b_tag_i(op_b_tag_o), .rob_tag_i(rob_tag_o), .rob_rd_i(rob_rd_o),
        .rob_opcode_i(rob_opcode_o),
        .pass_count_o(pass_count), .fail_count_o(fail_count), .done_count_o(done_count)
    );

    // one golden line onto the dut pins for a cycle
    task automatic present_test(input int n);
        logic [31:0] ctl;
        ctl = golden[n*FIELDS+4];
        @(posedge clk);
        instr_valid_i  <= 1'b1;
        instr_i        <= golden[n*FIELDS];
        pc_i           <= golden[n*FIELDS+1];
        reg_vj_i       <= golden[n*FIELDS+2];
        reg_vk_i       <= golden[n*FIELDS+3];
        reg_qj_i       <= ctl[31:28];
        reg_qk_i       <= ctl[27:24];
        rob_free_tag_i <= ctl[23:20];
        lsb_full_i     <= ctl[18];
        cmp_full_i     <= ctl[17];
        alu_full_i     <= ctl[16];
        rob_ready_i    <= ctl[15:0];
        exp_ctl        <= golden[n*FIELDS+5];
        exp_op_a       <= golden[n*FIELDS+6];
        exp_op_b       <= golden[n*FIELDS+7];
        exp_imm        <= golden[n*FIELDS+8];
        exp_rd         <= golden[n*FIELDS+9][4:0];
        test_id        <= n;
    endtask

    // queue empty for a cycle
    task automatic idle_cycle();
        @(posedge clk);
        instr_valid_i <= 1'b0;
    endtask

    initial begin
        int unsigned first_draw;
        int          gap;
        first_draw = $urandom(32'hf53a5b50);
        rst            <= 1'b1;
        instr_valid_i  <= 1'b0;
        instr_i        <= '0;
        pc_i           <= '0;
        reg_vj_i       <= '0;
        reg_vk_i       <= '0;
        reg_qj_i       <= '0;
        reg_qk_i       <= '0;
        rob_free_tag_i <= '0;
        rob_ready_i    <= '0;
        alu_full_i     <= 1'b0;
        cmp_full_i     <= 1'b0;
        lsb_full_i     <= 1'b0;
        // rob results, entry n holds beef0000 + n*0101
        for (int e = 0; e < decode_issue_pkg::ROB_ENTRIES; e++)
            rob_value_i[e] <= 32'hbeef0000 + e * 32'h0101;
        $readmemh("verification/decode_issue_golden.txt", golden);
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < NUM_TESTS; n++) begin
            present_test(n);
            // gap of zero keeps issue back to back
            gap = $urandom % 3;
            repeat (gap) idle_cycle();
        end
        idle_cycle();
        wait (done_count == NUM_TESTS);
        @(posedge clk);
        $display("tests %0d, ok %0d, bad %0d", done_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog, ten cycles per test on top of reset
    initial begin
        #((NUM_TESTS * 10 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: only %0d of %0d tests finished", done_count, NUM_TESTS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: project.f
src/decode_issue_pkg.sv
src/decode_if.sv
src/decode_fields.sv
src/operand_resolve.sv
src/issue_ctrl.sv
src/dispatch_regs.sv
src/decode_issue_top.sv
verification/decode_issue_checker.sv
verification/decode_issue_tb.sv

// File: verification/decode_issue_golden.txt
// instr pc reg_vj reg_vk ctl{qj,qk,free_tag,full[lsb,cmp,alu],ready[15:0]}
// exp{read,load,rename_tag,target,op,store,a_tag,b_tag} op_a op_b imm rob_rd
12345297 00001000 aaaa0001 aaaa0002 30100000 11110000 00001000 12345000 12345000 05 // auipc
00208333 00001004 00000011 00000022 00200000 11210000 00000011 00000022 00000002 06 // add
404183b3 00001008 00000100 00000040 00300000 11318000 00000100 00000040 00000404 07 // sub
00629433 0000100c 0000000f 00000004 00400000 11411000 0000000f 00000004 00000006 08 // sll
fff0c493 00001010 12340000 99999999 05500000 11514000 12340000 ffffffff ffffffff 09 // xori
7f016513 00001014 00000000 00000000 30600008 11616000 beef0303 000007f0 000007f0 0a // ori
0ff1f593 00001018 5555aaaa 00000000 50700008 11717050 5555aaaa 000000ff 000000ff 0b // andi
00527633 0000101c 00000000 0000dead 79800080 11817009 beef0707 0000dead 00000005 0c // and
00208863 00002000 00000005 00000005 00900000 10020000 00000005 00000005 00000010 00 // beq
fe41fce3 00002004 00000010 00000003 05a00020 10027000 00000010 beef0505 fffffff8 00 // bgeu
00812683 00003000 00008000 00000000 00b00000 11b32000 00008000 00000008 00000008 0d // lw
fe638e23 00003004 00004000 000000ab 02c00000 10030102 00004000 000000ab fffffffc 00 // sb
00208333 00001020 00000011 00000022 00d10000 00000000 00000000 00000000 00000000 00 // alu full
00812683 00003008 00008000 00000000 00e40000 00000000 00000000 00000000 00000000 00 // lsb full
00208863 00002008 00000005 00000005 00f20000 00000000 00000000 00000000 00000000 00 // cmp full
12345297 00001024 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00 // no tag
00000013 00001028 00000000 00000000 00100000 10000000 00000000 00000000 00000000 00 // x0
0020a2b3 0000102c 00000000 00000000 00200000 10000000 00000000 00000000 00000000 00 // slt
000012b7 00001030 00000000 00000000 00300000 10000000 00000000 00000000 00000000 00 // lui
0030d293 00001034 00000000 00000000 00400000 10000000 00000000 00000000 00000000 00 // srli
0020a623 0000300c 00001000 0badf00d 00510000 10032100 00001000 0badf00d 0000000c 00 // sw
